/* include/riscv_params.svh */
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Datapath and address widths
`define XLEN        32
`define WORD_ADDR_W 30

// Register file geometry
`define REG_ADDR_W  5
`define NUM_REGS    32

// First fetch address
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

`endif

/* rtl/riscv_pkg.sv */
`include "riscv_params.svh"

package riscv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5
    } alu_op_e;

    // Instruction format views, MSB first
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_4_0;
        opcode_e                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        opcode_e                opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
        b_fmt_t b_view;
        j_fmt_t j_view;
    } inst_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;  // Operand b from imm
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`WORD_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]        wdata;
    } bus_req_t;

endpackage

/* rtl/fetch_stage.sv */
`include "riscv_params.svh"

module fetch_stage import riscv_pkg::*; (
    input  logic             clk,
    input  logic             RST_n,
    input  logic             stall,
    input  logic             hold,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output bus_req_t         fetch_req,
    input  logic [`XLEN-1:0] fetch_rdata,
    output inst_u            if_inst,
    output logic [`XLEN-1:0] if_pc
);

    logic [`XLEN-1:0] pc;

    // Fetch always reads the word at pc
    assign fetch_req = '{valid: 1'b1, write: 1'b0, addr: pc[`XLEN-1:2], wdata: '0};

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc      <= `RESET_PC;
            if_inst <= `NOP_INST;
            if_pc   <= '0;
        end else if (!stall) begin
            if (redirect) begin
                pc      <= redirect_pc;
                if_inst <= `NOP_INST;  // Kill the wrong-path fetch
            end else if (!hold) begin
                pc      <= pc + `XLEN'd4;
                if_inst <= fetch_rdata;
                if_pc   <= pc;
            end
        end
    end

    // Decode must not redirect while a load-use bubble is pending
    a_no_redirect_on_hold: assert property (@(posedge clk) disable iff (!RST_n)
        !(redirect && hold));

endmodule

/* rtl/decode_stage.sv */
`include "riscv_params.svh"

module decode_stage import riscv_pkg::*; (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   stall,
    input  inst_u                  if_inst,
    input  logic [`XLEN-1:0]       if_pc,
    input  wb_t                    wb,
    input  wb_t                    ex_fwd,
    input  logic                   ex_rd_is_load,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic                   hold,
    output id_ex_t                 id_ex
);

    logic [`XLEN-1:0]       regs [`NUM_REGS];
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       imm, imm_i, imm_s, imm_b, imm_j;
    logic                   is_branch, is_jal, uses_rs1, uses_rs2, taken;
    logic [`REG_ADDR_W-1:0] rs1, rs2;
    logic [`XLEN-1:0]       rf_rs1, rf_rs2, br_rs1, br_rs2;
    id_ex_t                 id_next;

    function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // Take src when it writes idx, else keep fallback
    function automatic logic [`XLEN-1:0] fwd_pick(input logic [`REG_ADDR_W-1:0] idx,
                                                  input wb_t src,
                                                  input logic [`XLEN-1:0] fallback);
        if (src.en && src.rd == idx && idx != '0)
            return src.data;
        return fallback;
    endfunction

    assign rs1 = if_inst.r_view.rs1;
    assign rs2 = if_inst.r_view.rs2;

    // Immediates straight out of the format views
    assign imm_i = {{20{if_inst.i_view.imm[11]}}, if_inst.i_view.imm};
    assign imm_s = {{20{if_inst.s_view.imm_11_5[6]}}, if_inst.s_view.imm_11_5,
                    if_inst.s_view.imm_4_0};
    assign imm_b = {{19{if_inst.b_view.imm_12}}, if_inst.b_view.imm_12, if_inst.b_view.imm_11,
                    if_inst.b_view.imm_10_5, if_inst.b_view.imm_4_1, 1'b0};
    assign imm_j = {{11{if_inst.j_view.imm_20}}, if_inst.j_view.imm_20,
                    if_inst.j_view.imm_19_12, if_inst.j_view.imm_11,
                    if_inst.j_view.imm_10_1, 1'b0};

    always_comb begin
        ctrl      = '0;  // alu_op defaults to add
        imm       = '0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        case (if_inst.r_view.opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_of(if_inst.r_view.funct3, if_inst.r_view.funct7[5]);
                uses_rs2       = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_op_of(if_inst.i_view.funct3, 1'b0);
                imm              = imm_i;
            end
            OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
            end
            OPC_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s;
                uses_rs2         = 1'b1;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_JAL: begin
                is_jal           = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = `XLEN'd4;  // Link value is pc + 4
                uses_rs1         = 1'b0;
            end
            default: uses_rs1 = 1'b0;
        endcase
    end

    // Load in execute feeding this instruction
    assign hold = ex_rd_is_load && ex_rd != '0 &&
                  ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

    assign rf_rs1 = fwd_pick(rs1, wb, regs[rs1]);
    assign rf_rs2 = fwd_pick(rs2, wb, regs[rs2]);
    assign br_rs1 = fwd_pick(rs1, ex_fwd, rf_rs1);  // Youngest producer wins
    assign br_rs2 = fwd_pick(rs2, ex_fwd, rf_rs2);

    // funct3[0] selects bne
    assign taken       = is_branch && ((br_rs1 == br_rs2) ^ if_inst.b_view.funct3[0]);
    assign redirect    = (taken || is_jal) && !hold;
    assign redirect_pc = if_pc + (is_jal ? imm_j : imm_b);

    always_comb begin
        id_next.valid   = 1'b1;
        id_next.ctrl    = ctrl;
        id_next.rs1_val = is_jal ? if_pc : rf_rs1;
        id_next.rs2_val = rf_rs2;
        id_next.rs1     = uses_rs1 ? rs1 : '0;
        id_next.rs2     = uses_rs2 ? rs2 : '0;
        id_next.rd      = if_inst.r_view.rd;
        id_next.imm     = imm;
    end

    always_ff @(posedge clk) begin
        if (!RST_n)
            id_ex <= '0;
        else if (!stall)
            id_ex <= hold ? '0 : id_next;  // Bubble on load-use
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (!stall && wb.en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!RST_n) regs[0] == '0);

    // Load-use bubble lasts one cycle
    a_hold_one_cycle: assert property (@(posedge clk) disable iff (!RST_n)
        (hold && !stall) |=> !hold);

endmodule

/* rtl/execute_stage.sv */
`include "riscv_params.svh"

module execute_stage import riscv_pkg::*; (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   stall,
    input  id_ex_t                 id_ex,
    input  wb_t                    wb,
    output ex_mem_t                ex_mem,
    output wb_t                    ex_fwd,
    output logic                   ex_rd_is_load,
    output logic [`REG_ADDR_W-1:0] ex_rd
);

    logic [`XLEN-1:0] op_a, op_b, rs2_v, alu_out;

    // Producer in mem_wb shows up on wb, loads included
    function automatic logic [`XLEN-1:0] operand(input logic [`REG_ADDR_W-1:0] idx,
                                                 input logic [`XLEN-1:0] reg_val);
        if (idx == '0)
            return reg_val;
        if (wb.en && wb.rd == idx)
            return wb.data;
        return reg_val;
    endfunction

    assign op_a  = operand(id_ex.rs1, id_ex.rs1_val);
    assign rs2_v = operand(id_ex.rs2, id_ex.rs2_val);
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_v;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // Result toward decode for branch compare
    assign ex_fwd = '{en:   id_ex.valid && id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read,
                      rd:   id_ex.rd,
                      data: alu_out};

    assign ex_rd_is_load = id_ex.valid && id_ex.ctrl.mem_read;
    assign ex_rd         = id_ex.rd;

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_out;
            ex_mem.store_data <= rs2_v;
        end
    end

endmodule

/* rtl/mem_wb_stage.sv */
`include "riscv_params.svh"

module mem_wb_stage import riscv_pkg::*; (
    input  ex_mem_t          ex_mem,
    output bus_req_t         data_req,
    input  logic [`XLEN-1:0] data_rdata,
    output wb_t              wb
);

    logic access;

    assign access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // Word access, low address bits dropped
    always_comb begin
        data_req.valid = access;
        data_req.write = ex_mem.valid && ex_mem.mem_write;
        data_req.addr  = ex_mem.alu_result[`XLEN-1:2];
        data_req.wdata = ex_mem.store_data;
    end

    always_comb begin
        wb.en   = ex_mem.valid && ex_mem.reg_write;
        wb.rd   = ex_mem.rd;
        wb.data = ex_mem.mem_read ? data_rdata : ex_mem.alu_result;
    end

endmodule

/* rtl/mem_arbiter.sv */
`include "riscv_params.svh"

module mem_arbiter import riscv_pkg::*; (
    input  logic             clk,
    input  logic             RST_n,
    input  bus_req_t         fetch_req,
    input  bus_req_t         data_req,
    output bus_req_t         mem_req,
    input  logic [`XLEN-1:0] mem_rdata,
    input  logic             mem_ready,
    output logic [`XLEN-1:0] fetch_rdata,
    output logic [`XLEN-1:0] data_rdata,
    output logic             stall
);

    logic             data_done_q;  // Data side finished, fetch still owed
    logic             data_active;
    logic [`XLEN-1:0] rdata_q;

    assign data_active = data_req.valid && !data_done_q;
    assign mem_req     = data_active ? data_req : fetch_req;
    assign fetch_rdata = mem_rdata;
    assign data_rdata  = data_done_q ? rdata_q : mem_rdata;

    // Data owns the port, or fetch is waiting on ready
    assign stall = data_active || (fetch_req.valid && !mem_ready);

    always_ff @(posedge clk) begin
        if (!RST_n)
            data_done_q <= 1'b0;
        else if (!stall)
            data_done_q <= 1'b0;
        else if (data_active && mem_ready)
            data_done_q <= 1'b1;
    end

    // Load data kept until the pipeline moves
    always_ff @(posedge clk) begin
        if (data_active && mem_ready)
            rdata_q <= mem_rdata;
    end

    a_write_owner: assert property (@(posedge clk) disable iff (!RST_n)
        mem_req.write |-> data_active);

endmodule

/* rtl/riscv_core.sv */
`include "riscv_params.svh"

module riscv_core import riscv_pkg::*; (
    input  logic             clk,
    input  logic             RST_n,
    output bus_req_t         mem_req,
    input  logic [`XLEN-1:0] mem_rdata,
    input  logic             mem_ready
);

    bus_req_t               fetch_req, data_req;
    logic [`XLEN-1:0]       fetch_rdata, data_rdata;
    logic                   stall, hold, redirect;
    logic [`XLEN-1:0]       redirect_pc, if_pc;
    inst_u                  if_inst;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    wb_t                    wb, ex_fwd;
    logic                   ex_rd_is_load;
    logic [`REG_ADDR_W-1:0] ex_rd;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .RST_n       (RST_n),
        .stall       (stall),
        .hold        (hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_rdata (fetch_rdata),
        .if_inst     (if_inst),
        .if_pc       (if_pc)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .RST_n         (RST_n),
        .stall         (stall),
        .if_inst       (if_inst),
        .if_pc         (if_pc),
        .wb            (wb),
        .ex_fwd        (ex_fwd),
        .ex_rd_is_load (ex_rd_is_load),
        .ex_rd         (ex_rd),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .hold          (hold),
        .id_ex         (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk           (clk),
        .RST_n         (RST_n),
        .stall         (stall),
        .id_ex         (id_ex),
        .wb            (wb),
        .ex_mem        (ex_mem),
        .ex_fwd        (ex_fwd),
        .ex_rd_is_load (ex_rd_is_load),
        .ex_rd         (ex_rd)
    );

    mem_wb_stage mem_wb_stage_inst (
        .ex_mem     (ex_mem),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .wb         (wb)
    );

    // Single shared port, data first
    mem_arbiter mem_arbiter_inst (
        .clk         (clk),
        .RST_n       (RST_n),
        .fetch_req   (fetch_req),
        .data_req    (data_req),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .fetch_rdata (fetch_rdata),
        .data_rdata  (data_rdata),
        .stall       (stall)
    );

endmodule

/* verif/sim_memory.sv */
`include "riscv_params.svh"

module sim_memory import riscv_pkg::*; (
    input  logic             clk,
    input  logic             RST_n,
    input  bus_req_t         mem_req,
    output logic [`XLEN-1:0] mem_rdata,
    output logic             mem_ready,
    output logic             store_seen,
    output logic [`XLEN-1:0] store_addr,
    output logic [`XLEN-1:0] store_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH    = 256;
    localparam int WAIT_PCT = 30;

    logic [`XLEN-1:0] mem [DEPTH];
    logic             wait_q;
    logic             write_ok;

    // Every bit of the word index shows up in the pattern
    function automatic logic [`XLEN-1:0] fill_word(input logic [7:0] idx);
        return {8'hC5, idx ^ 8'h5A, ~idx, idx};
    endfunction

    initial begin
        void'($urandom(32'h58ff));
        wait_q <= 1'b0;
        for (int i = 0; i < DEPTH; i++)
            mem[i] <= fill_word(i[7:0]);
    end

    assign mem_rdata = mem[mem_req.addr[7:0]];  // Same-cycle read data
    assign mem_ready = !wait_q;
    assign write_ok  = RST_n && mem_req.valid && mem_req.write && mem_ready;

    always @(posedge clk) begin
        wait_q     <= ($urandom % 100) < WAIT_PCT;
        store_seen <= write_ok;  // One-cycle pulse per completed store
        store_addr <= {mem_req.addr, 2'b00};
        store_data <= mem_req.wdata;
        if (write_ok) begin
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
            $display("Store %h <= %h", {mem_req.addr, 2'b00}, mem_req.wdata);
        end
    end

endmodule

/* verif/tb_riscv_core.sv */
`include "riscv_params.svh"

module tb_riscv_core import riscv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STORE_TIMEOUT = 2000;
    localparam int QUIET_CYCLES  = 100;

    // RV32I opcodes and function codes
    localparam logic [6:0] OP      = 7'b0110011;
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] LOAD    = 7'b0000011;
    localparam logic [6:0] STORE   = 7'b0100011;
    localparam logic [6:0] BRANCH  = 7'b1100011;
    localparam logic [6:0] JAL     = 7'b1101111;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    logic             clk = 1'b0;
    logic             RST_n;
    bus_req_t         mem_req;
    logic [`XLEN-1:0] mem_rdata;
    logic             mem_ready;
    logic             store_seen;
    logic [`XLEN-1:0] store_addr;
    logic [`XLEN-1:0] store_data;

    logic [31:0] prog [$];      // Program words from address 0
    string       exp_name [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          errors;
    int          checked;
    bit          timed_out;

    always #4 clk = ~clk;

    riscv_core riscv_core_inst (
        .clk       (clk),
        .RST_n     (RST_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    sim_memory sim_memory_inst (
        .clk        (clk),
        .RST_n      (RST_n),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .store_seen (store_seen),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    function automatic logic [31:0] r_word(input logic [2:0] f3, input logic [6:0] f7,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_store(input string name, input int addr, input int data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        int a;
        int b;
        int base;
        int jal_pc;
        a    = 100;
        b    = -7;
        base = 512;
        emit(i_word(OP_IMM, F3_ADD, 1, 0, base));
        emit(i_word(OP_IMM, F3_ADD, 2, 0, a));
        emit(i_word(OP_IMM, F3_ADD, 3, 0, b));
        emit(r_word(F3_ADD, 7'h00, 4, 2, 3));
        emit(s_word(4, 1, 0));                  expect_store("add", base + 0, a + b);
        emit(r_word(F3_ADD, F7_SUB, 5, 2, 3));
        emit(s_word(5, 1, 4));                  expect_store("sub", base + 4, a - b);
        emit(r_word(F3_AND, 7'h00, 6, 2, 3));
        emit(s_word(6, 1, 8));                  expect_store("and", base + 8, a & b);
        emit(r_word(F3_OR, 7'h00, 7, 2, 3));
        emit(s_word(7, 1, 12));                 expect_store("or", base + 12, a | b);
        emit(r_word(F3_XOR, 7'h00, 8, 2, 3));
        emit(s_word(8, 1, 16));                 expect_store("xor", base + 16, a ^ b);
        emit(r_word(F3_SLT, 7'h00, 9, 3, 2));   // Signed, negative first
        emit(s_word(9, 1, 20));
        expect_store("slt_lt", base + 20, (b < a) ? 1 : 0);
        emit(r_word(F3_SLT, 7'h00, 10, 2, 3));
        emit(s_word(10, 1, 24));
        expect_store("slt_ge", base + 24, (a < b) ? 1 : 0);
        emit(i_word(OP_IMM, F3_ADD, 11, 3, 50));
        emit(s_word(11, 1, 28));                expect_store("addi", base + 28, b + 50);
        emit(i_word(OP_IMM, F3_AND, 12, 2, 15));
        emit(s_word(12, 1, 32));                expect_store("andi", base + 32, a & 15);
        emit(i_word(OP_IMM, F3_OR, 13, 12, 256));
        emit(s_word(13, 1, 36));                expect_store("ori", base + 36, (a & 15) | 256);
        emit(i_word(OP_IMM, F3_XOR, 14, 13, -1));
        emit(s_word(14, 1, 40));
        expect_store("xori", base + 40, ((a & 15) | 256) ^ -1);
        emit(i_word(OP_IMM, F3_SLT, 15, 14, -200));
        emit(s_word(15, 1, 44));
        expect_store("slti", base + 44, ((((a & 15) | 256) ^ -1) < -200) ? 1 : 0);
        // Dependent chain at distances 1, 2 and 3
        emit(i_word(OP_IMM, F3_ADD, 16, 0, 5));
        emit(i_word(OP_IMM, F3_ADD, 17, 16, 3));
        emit(i_word(OP_IMM, F3_ADD, 18, 16, 10));
        emit(i_word(OP_IMM, F3_ADD, 19, 16, 20));
        emit(r_word(F3_ADD, 7'h00, 20, 17, 18));
        emit(r_word(F3_ADD, 7'h00, 21, 20, 19));
        emit(s_word(21, 1, 48));                expect_store("fwd_chain", base + 48, 48);
        emit(s_word(17, 1, 52));                expect_store("fwd_d1", base + 52, 8);
        emit(s_word(18, 1, 56));                expect_store("fwd_d2", base + 56, 15);
        emit(s_word(19, 1, 60));                expect_store("fwd_d3", base + 60, 25);
        // Reload the sub result, use it right away
        emit(i_word(LOAD, F3_WORD, 22, 1, 4));
        emit(r_word(F3_ADD, 7'h00, 23, 22, 2));
        emit(s_word(23, 1, 64));                expect_store("load_use", base + 64, a - b + a);
        emit(i_word(OP_IMM, F3_ADD, 24, 0, 9));
        emit(b_word(F3_BEQ, 24, 24, 8));        // Taken, operand from execute
        emit(s_word(24, 1, 256));               // Wrong path
        emit(b_word(F3_BNE, 24, 2, 8));         // Taken
        emit(s_word(24, 1, 260));               // Wrong path
        emit(b_word(F3_BEQ, 24, 2, 8));
        emit(s_word(24, 1, 68));                expect_store("beq_not_taken", base + 68, 9);
        emit(b_word(F3_BNE, 24, 24, 8));
        emit(s_word(2, 1, 72));                 expect_store("bne_not_taken", base + 72, a);
        jal_pc = prog.size() * 4;
        emit(j_word(25, 8));
        emit(s_word(24, 1, 264));               // Skipped by jal
        emit(s_word(25, 1, 76));                expect_store("jal_link", base + 76, jal_pc + 4);
        emit(i_word(OP_IMM, F3_ADD, 26, 0, 1));
        emit(s_word(26, 1, 508));               expect_store("done", base + 508, 1);
        emit(j_word(0, 0));                     // Spin
    endtask

    task automatic wait_store(output bit got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            got = store_seen;
            cycles++;
        end
    endtask

    initial begin
        bit got;
        errors    = 0;
        checked   = 0;
        timed_out = 1'b0;
        RST_n     <= 1'b0;
        build_program();
        @(posedge clk);
        foreach (prog[i])
            sim_memory_inst.mem[i] <= prog[i];
        repeat (9) @(posedge clk);
        RST_n <= 1'b1;

        foreach (exp_name[k]) begin
            wait_store(got);
            if (!got) begin
                $display("Timeout: store %s never arrived within %0d cycles",
                         exp_name[k], STORE_TIMEOUT);
                errors++;
                timed_out = 1'b1;
                break;
            end
            checked++;
            if (store_addr !== exp_addr[k] || store_data !== exp_data[k]) begin
                $display("Mismatch %s: expected %h at %h, actual %h at %h", exp_name[k],
                         exp_data[k], exp_addr[k], store_data, store_addr);
                errors++;
            end
        end

        // Spin loop must stay silent on the bus
        if (!timed_out) begin
            for (int n = 0; n < QUIET_CYCLES; n++) begin
                @(posedge clk);
                if (store_seen) begin
                    $display("Unexpected store of %h at %h after the last one",
                             store_data, store_addr);
                    errors++;
                end
            end
        end

        $display("Checked %0d of %0d stores, %0d errors", checked, exp_name.size(), errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* riscv_core.f */
+incdir+include
rtl/riscv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/mem_arbiter.sv
rtl/riscv_core.sv
verif/sim_memory.sv
verif/tb_riscv_core.sv

/* Makefile */
TOP := tb_riscv_core
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir $(OBJ) -f riscv_core.f
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ)
